// ==== files.f ====
hdl/cpu_pkg.sv
hdl/button_debounce.sv
hdl/alu.sv
hdl/control_unit.sv
hdl/program_rom.sv
hdl/cpu_core.sv
hdl/display_ctrl.sv
hdl/board_top.sv
dv/board_props.sv
dv/tb_board_top.sv

// ==== dv/tb_board_top.sv ====
/* Testbench for board_top with a short debounce limit.
   Expected display values come from a model of the countdown program. */
`timescale 1ns/1ns
`default_nettype none

module tb_board_top;

    localparam logic [15:0] DEBOUNCE_LIMIT = 16'd8;
    localparam int STEP_WAIT = 16;                        // Covers DEBOUNCE_LIMIT+2
    localparam int PRESS_MAX = 2 * STEP_WAIT + 14;        // Bounce, hold, release, check
    localparam int PRESSES   = 60 + 4 * 12 + 4;           // Loop, mode rounds, glitches
    localparam int TIMEOUT   = 16 + PRESSES * PRESS_MAX + 200;
    localparam int SEED      = 32'h085a590d;

    logic       CLK;
    logic       rst;
    logic       i_step_n;
    logic       i_mode_n;
    logic [3:0] o_led;
    logic [6:0] o_seg_tens_n;
    logic [6:0] o_seg_ones_n;

    integer     seed;
    int         cycle_count = 0;
    logic       check_req;      // One-cycle compare request
    logic [7:0] m_pc;           // Model state
    logic [7:0] m_a;
    logic [7:0] m_b;
    logic       m_z;            // Z latched by the last step
    logic [1:0] m_mode;

    board_top #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) dut_i (
        .CLK          (CLK),
        .rst          (rst),
        .i_step_n     (i_step_n),
        .i_mode_n     (i_mode_n),
        .o_led        (o_led),
        .o_seg_tens_n (o_seg_tens_n),
        .o_seg_ones_n (o_seg_ones_n)
    );

    always #4 CLK = ~CLK;  // 8 ns period

    // ALU output of the program entry at pc
    function automatic logic [7:0] model_alu(input logic [7:0] pc, input logic [7:0] a,
                                             input logic [7:0] b);
        case (pc)
            8'd1:       model_alu = 8'd15;
            8'd3:       model_alu = 8'd1;
            8'd4:       model_alu = a - b;
            8'd5, 8'd6: model_alu = a + b;   // Jumps add A and B
            default:    model_alu = b;       // A <- B entries
        endcase
    endfunction

    function automatic logic [3:0] expected_nibble(input logic [1:0] mode);
        logic [7:0] val;
        case (mode)
            2'd0:    val = m_pc;
            2'd1:    val = m_a;
            2'd2:    val = m_b;
            default: val = model_alu(m_pc, m_a, m_b);
        endcase
        expected_nibble = val[3:0];
    endfunction

    // Active-low segments A..G from bit 6 down
    function automatic logic [6:0] digit_pattern(input int d);
        case (d)
            0:       digit_pattern = 7'b0000001;
            1:       digit_pattern = 7'b1001111;
            2:       digit_pattern = 7'b0010010;
            3:       digit_pattern = 7'b0000110;
            4:       digit_pattern = 7'b1001100;
            5:       digit_pattern = 7'b0100100;
            6:       digit_pattern = 7'b0100000;
            7:       digit_pattern = 7'b0001111;
            8:       digit_pattern = 7'b0000000;
            default: digit_pattern = 7'b0000100;
        endcase
    endfunction

    // {tens, ones} patterns for a nibble
    function automatic logic [13:0] display_segments(input logic [3:0] n);
        if (n >= 4'd10)
            display_segments = {digit_pattern(1), digit_pattern(n - 10)};
        else
            display_segments = {digit_pattern(0), digit_pattern(n)};
    endfunction

    task automatic advance_model();
        logic [7:0] alu;
        alu = model_alu(m_pc, m_a, m_b);
        if (m_pc == 8'd0 || m_pc == 8'd2 || m_pc == 8'd4)
            m_a = alu;
        if (m_pc == 8'd1 || m_pc == 8'd3)
            m_b = alu;
        if (m_pc == 8'd5)
            m_pc = m_z ? 8'd6 : 8'd4;  // JNZ reads the old Z
        else if (m_pc == 8'd6)
            m_pc = 8'd0;
        else
            m_pc = m_pc + 8'd1;
        m_z = (alu == 8'd0);  // Every step including jumps
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Level held for exactly `cycles` sampling edges
    task automatic drive_button(input bit is_mode, input logic level, input int cycles);
        @(posedge CLK);
        if (is_mode)
            i_mode_n <= level;
        else
            i_step_n <= level;
        repeat (cycles - 1) @(posedge CLK);
    endtask

    task automatic press_button(input bit is_mode);
        int bounces;
        int i;
        bounces = $unsigned($random(seed)) % 3;
        for (i = 0; i < bounces; i++) begin  // Contact bounce too short to count
            drive_button(is_mode, 1'b0, 1 + $unsigned($random(seed)) % 2);
            drive_button(is_mode, 1'b1, 1 + $unsigned($random(seed)) % 2);
        end
        drive_button(is_mode, 1'b0, STEP_WAIT);
        drive_button(is_mode, 1'b1, STEP_WAIT);  // Release settles too
    endtask

    task automatic request_check();
        @(posedge CLK);
        check_req <= 1'b1;
        @(posedge CLK);
        check_req <= 1'b0;
    endtask

    task automatic step_once();
        press_button(1'b0);
        advance_model();
        request_check();
    endtask

    task automatic next_mode();
        press_button(1'b1);
        m_mode = m_mode + 2'd1;
        request_check();
    endtask

    // Sampled mid-cycle away from the driving edge
    always @(negedge CLK) begin : compare_display
        logic [3:0]  nib;
        logic [13:0] segs;
        if (check_req) begin
            nib  = expected_nibble(m_mode);
            segs = display_segments(nib);
            check_value("LED value", o_led, nib);
            check_value("tens digit", o_seg_tens_n, segs[13:7]);
            check_value("ones digit", o_seg_ones_n, segs[6:0]);
        end
    end

    // First bound assertion failure ends the run
    always @(negedge CLK) begin : watch_props
        if (dut_i.cpu_i.cpu_props_i.fail_count +
            dut_i.disp_i.disp_props_i.fail_count != 0) begin
            $display("a bound assertion failed by %0t ns", $time);
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin : stimulus
        int n;
        int r;
        int g;
        int prop_fails;
        seed      = SEED;
        CLK       = 1'b0;
        rst       = 1'b1;
        i_step_n  = 1'b1;  // Buttons idle high
        i_mode_n  = 1'b1;
        check_req = 1'b0;
        m_pc      = 8'd0;
        m_a       = 8'd0;
        m_b       = 8'd0;
        m_z       = 1'b0;
        m_mode    = 2'd0;
        repeat (16) @(posedge CLK);
        rst <= 1'b0;
        request_check();              // PC 0 shows 00
        repeat (60) step_once();      // Countdown, fall-through, jump to 0
        for (r = 0; r < 4; r++) begin
            n = 1 + $unsigned($random(seed)) % 8;
            repeat (n) step_once();
            repeat (4) next_mode();   // A, B, ALU, back to PC
        end
        for (r = 0; r < 4; r++) begin
            g = 1 + $unsigned($random(seed)) % (DEBOUNCE_LIMIT - 1);
            drive_button(1'b0, 1'b0, g);
            drive_button(1'b0, 1'b1, STEP_WAIT);
            request_check();          // PC must not move
        end
        prop_fails = dut_i.cpu_i.cpu_props_i.fail_count +
                     dut_i.disp_i.disp_props_i.fail_count;
        if (prop_fails == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures were seen", prop_fails);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== dv/board_props.sv ====
/* Properties for cpu_core and display_ctrl, bound into both.
   Ports unused by a target are tied to constant legal values. */
`timescale 1ns/1ns
`default_nettype none

module board_props (
    input logic                       CLK,
    input logic                       rst,
    input logic                       i_step,
    input logic [cpu_pkg::DATA_W-1:0] i_pc,
    input logic                       i_next_mode,
    input logic [1:0]                 i_mode,
    input logic [6:0]                 i_seg_tens_n
);

    int fail_count = 0;  // Read by the testbench at the end

    pc_moves_on_step: assert property (@(posedge CLK) disable iff (rst)
        (i_pc != $past(i_pc)) |-> $past(i_step))
        else begin
            fail_count++;
            $error("PC changed without a step");
        end

    mode_moves_on_press: assert property (@(posedge CLK) disable iff (rst)
        (i_mode != $past(i_mode)) |-> $past(i_next_mode))
        else begin
            fail_count++;
            $error("display mode changed without a mode press");
        end

    // Tens digit is 0 or 1 only
    tens_is_0_or_1: assert property (@(posedge CLK) disable iff (rst)
        (i_seg_tens_n == 7'b0000001) || (i_seg_tens_n == 7'b1001111))
        else begin
            fail_count++;
            $error("tens digit shows neither 0 nor 1");
        end

endmodule

bind cpu_core board_props cpu_props_i (
    .CLK          (CLK),
    .rst          (rst),
    .i_step       (i_step),
    .i_pc         (pc),
    .i_next_mode  (1'b0),
    .i_mode       (2'd0),
    .i_seg_tens_n (7'b0000001)
);

bind display_ctrl board_props disp_props_i (
    .CLK          (CLK),
    .rst          (rst),
    .i_step       (1'b0),
    .i_pc         (8'd0),
    .i_next_mode  (i_next_mode),
    .i_mode       (mode),
    .i_seg_tens_n (o_seg_tens_n)
);

`default_nettype wire

// ==== hdl/board_top.sv ====
/* Front panel top level. Step and mode buttons are active low and noisy.
   rst is used without debouncing. */
`timescale 1ns/1ns
`default_nettype none

module board_top #(
    parameter logic [15:0] DEBOUNCE_LIMIT = 16'd10000  // Cycles a button must hold
) (
    input  logic       CLK,
    input  logic       rst,
    input  logic       i_step_n,
    input  logic       i_mode_n,
    output logic [3:0] o_led,
    output logic [6:0] o_seg_tens_n,
    output logic [6:0] o_seg_ones_n
);
    import cpu_pkg::*;

    logic              step_press;
    logic              mode_press;
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] alu_result;

    button_debounce #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) step_db_i (
        .i_clk   (CLK),
        .rst     (rst),
        .i_btn_n (i_step_n),
        .o_press (step_press)
    );

    button_debounce #(.DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)) mode_db_i (
        .i_clk   (CLK),
        .rst     (rst),
        .i_btn_n (i_mode_n),
        .o_press (mode_press)
    );

    cpu_core cpu_i (
        .CLK          (CLK),
        .rst          (rst),
        .i_step       (step_press),  // One instruction per press
        .o_pc         (pc),
        .o_reg_a      (reg_a),
        .o_reg_b      (reg_b),
        .o_alu_result (alu_result)
    );

    display_ctrl disp_i (
        .CLK          (CLK),
        .rst          (rst),
        .i_next_mode  (mode_press),
        .i_pc         (pc),
        .i_reg_a      (reg_a),
        .i_reg_b      (reg_b),
        .i_alu_result (alu_result),
        .o_led        (o_led),
        .o_seg_tens_n (o_seg_tens_n),
        .o_seg_ones_n (o_seg_ones_n)
    );

endmodule

`default_nettype wire

// ==== hdl/display_ctrl.sv ====
/* Shows the low nibble of PC, A, B or the ALU result on LEDs and two digits.
   Segments are active low, A..G from bit 6 down. Outputs are combinational. */
`timescale 1ns/1ns
`default_nettype none

module display_ctrl (
    input  logic                         CLK,
    input  logic                         rst,
    input  logic                         i_next_mode,
    input  logic [cpu_pkg::DATA_W-1:0]   i_pc,
    input  logic [cpu_pkg::DATA_W-1:0]   i_reg_a,
    input  logic [cpu_pkg::DATA_W-1:0]   i_reg_b,
    input  logic [cpu_pkg::DATA_W-1:0]   i_alu_result,
    output logic [cpu_pkg::NIBBLE_W-1:0] o_led,
    output logic [6:0]                   o_seg_tens_n,
    output logic [6:0]                   o_seg_ones_n
);
    import cpu_pkg::*;

    logic [1:0]          mode;    // 0 PC, 1 A, 2 B, 3 ALU
    logic [NIBBLE_W-1:0] nibble;
    logic                tens;
    logic [NIBBLE_W-1:0] ones;

    function automatic logic [6:0] seg_pattern(input logic [NIBBLE_W-1:0] digit);
        case (digit)
            4'd0:    seg_pattern = 7'b0000001;
            4'd1:    seg_pattern = 7'b1001111;
            4'd2:    seg_pattern = 7'b0010010;
            4'd3:    seg_pattern = 7'b0000110;
            4'd4:    seg_pattern = 7'b1001100;
            4'd5:    seg_pattern = 7'b0100100;
            4'd6:    seg_pattern = 7'b0100000;
            4'd7:    seg_pattern = 7'b0001111;
            4'd8:    seg_pattern = 7'b0000000;
            4'd9:    seg_pattern = 7'b0000100;
            default: seg_pattern = 7'b1111111;  // Blank
        endcase
    endfunction

    always_ff @(posedge CLK or posedge rst) begin
        if (rst)
            mode <= 2'd0;
        else if (i_next_mode)
            mode <= mode + 1'b1;  // Wraps 3 to 0
    end

    always_comb begin
        case (mode)
            2'd0:    nibble = i_pc[NIBBLE_W-1:0];
            2'd1:    nibble = i_reg_a[NIBBLE_W-1:0];
            2'd2:    nibble = i_reg_b[NIBBLE_W-1:0];
            default: nibble = i_alu_result[NIBBLE_W-1:0];
        endcase
    end

    // Nibble tops out at 15 so the tens digit is 0 or 1
    assign tens = (nibble >= 4'd10);
    assign ones = tens ? nibble - 4'd10 : nibble;

    assign o_led        = nibble;
    assign o_seg_tens_n = seg_pattern({{(NIBBLE_W-1){1'b0}}, tens});
    assign o_seg_ones_n = seg_pattern(ones);

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
/* Single-cycle CPU core. State advances only on a CLK edge with i_step high.
   Conditional jumps see the flags captured by the previous step. */
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
    input  logic                       CLK,
    input  logic                       rst,
    input  logic                       i_step,
    output logic [cpu_pkg::DATA_W-1:0] o_pc,
    output logic [cpu_pkg::DATA_W-1:0] o_reg_a,
    output logic [cpu_pkg::DATA_W-1:0] o_reg_b,
    output logic [cpu_pkg::DATA_W-1:0] o_alu_result
);
    import cpu_pkg::*;

    logic [DATA_W-1:0]  pc;
    logic [DATA_W-1:0]  reg_a;
    logic [DATA_W-1:0]  reg_b;
    logic [FLAG_W-1:0]  status;     // Z N C V
    logic [INSTR_W-1:0] instr;
    logic [DATA_W-1:0]  literal;
    logic               pc_load;
    logic               load_a;
    logic               load_b;
    logic [1:0]         sel_a;
    logic [1:0]         sel_b;
    logic [2:0]         alu_op;
    logic [DATA_W-1:0]  op_a;
    logic [DATA_W-1:0]  op_b;
    logic [DATA_W-1:0]  alu_result;
    logic [FLAG_W-1:0]  alu_flags;

    assign literal = instr[DATA_W-1:0];

    program_rom rom_i (
        .i_addr  (pc),
        .o_instr (instr)
    );

    control_unit cu_i (
        .i_opcode  (instr[INSTR_W-1 -: OPC_W]),
        .i_flags   (status),
        .o_pc_load (pc_load),
        .o_load_a  (load_a),
        .o_load_b  (load_b),
        .o_sel_a   (sel_a),
        .o_sel_b   (sel_b),
        .o_alu_op  (alu_op)
    );

    always_comb begin
        case (sel_a)
            SEL_A_REG:  op_a = reg_a;
            SEL_A_ONE:  op_a = DATA_W'(1);
            SEL_A_ZERO: op_a = '0;
            SEL_A_B:    op_a = reg_b;
            default:    op_a = reg_a;
        endcase
        case (sel_b)
            SEL_B_REG: op_b = reg_b;
            SEL_B_LIT: op_b = literal;
            default:   op_b = '0;  // Old memory code also reads zero
        endcase
    end

    alu alu_i (
        .i_a      (op_a),
        .i_b      (op_b),
        .i_op     (alu_op),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            pc     <= '0;
            reg_a  <= '0;
            reg_b  <= '0;
            status <= '0;
        end else if (i_step) begin
            pc     <= pc_load ? literal : pc + 1'b1;
            status <= alu_flags;          // Every step, jumps included
            if (load_a)
                reg_a <= alu_result;
            if (load_b)
                reg_b <= alu_result;
        end
    end

    assign o_pc         = pc;
    assign o_reg_a      = reg_a;
    assign o_reg_b      = reg_b;
    assign o_alu_result = alu_result;

endmodule

`default_nettype wire

// ==== hdl/program_rom.sv ====
/* Fixed countdown program. A counts 15 down to 0, then the loop restarts.
   Addresses past 6 read as opcode 0 with literal 0. */
`timescale 1ns/1ns
`default_nettype none

module program_rom (
    input  logic [cpu_pkg::ADDR_W-1:0]  i_addr,
    output logic [cpu_pkg::INSTR_W-1:0] o_instr
);
    import cpu_pkg::*;

    // Word is {opcode, literal}
    always_comb begin
        case (i_addr)
            8'd0:    o_instr = {7'h00, 8'd0};     // A <- B
            8'd1:    o_instr = {7'h03, 8'd15};    // B <- 15
            8'd2:    o_instr = {7'h00, 8'd0};     // A <- B
            8'd3:    o_instr = {7'h03, 8'd1};     // B <- 1
            8'd4:    o_instr = {7'h08, 8'd0};     // A <- A - B
            8'd5:    o_instr = {OPC_JNZ, 8'd4};   // Loop while A nonzero
            8'd6:    o_instr = {OPC_JMP, 8'd0};
            default: o_instr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
/* Opcode to control word table. Opcodes 0x00-0x23 and jumps 0x53-0x5B only.
   A false condition or an unknown opcode gives an all-zero word. */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  logic [cpu_pkg::OPC_W-1:0]  i_opcode,
    input  logic [cpu_pkg::FLAG_W-1:0] i_flags,
    output logic                       o_pc_load,
    output logic                       o_load_a,
    output logic                       o_load_b,
    output logic [1:0]                 o_sel_a,
    output logic [1:0]                 o_sel_b,
    output logic [2:0]                 o_alu_op
);
    import cpu_pkg::*;

    localparam logic [CW_W-1:0] CW_JUMP = {3'b100, SEL_A_REG, SEL_B_REG, ALU_ADD};

    logic [CW_W-1:0] cw;
    logic            take;  // Jump condition on latched flags

    always_comb begin
        case (i_opcode)
            OPC_JMP: take = 1'b1;
            OPC_JZ:  take = i_flags[FLAG_Z];
            OPC_JNZ: take = ~i_flags[FLAG_Z];
            OPC_JGT: take = ~i_flags[FLAG_Z] & ~i_flags[FLAG_N];
            OPC_JN:  take = i_flags[FLAG_N];
            OPC_JNN: take = ~i_flags[FLAG_N];
            OPC_JLE: take = i_flags[FLAG_Z] | i_flags[FLAG_N];
            OPC_JC:  take = i_flags[FLAG_C];
            OPC_JV:  take = i_flags[FLAG_V];
            default: take = 1'b0;
        endcase
    end

    // Loads are {pc, a, b}
    always_comb begin
        case (i_opcode)
            7'h00: cw = {3'b010, SEL_A_ZERO, SEL_B_REG,  ALU_ADD};  // A <- B
            7'h01: cw = {3'b001, SEL_A_REG,  SEL_B_ZERO, ALU_ADD};  // B <- A
            7'h02: cw = {3'b010, SEL_A_ZERO, SEL_B_LIT,  ALU_ADD};  // A <- lit
            7'h03: cw = {3'b001, SEL_A_ZERO, SEL_B_LIT,  ALU_ADD};  // B <- lit
            7'h04: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_ADD};
            7'h05: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_ADD};
            7'h06: cw = {3'b010, SEL_A_REG,  SEL_B_LIT,  ALU_ADD};
            7'h07: cw = {3'b001, SEL_A_B,    SEL_B_LIT,  ALU_ADD};  // B <- B + lit
            7'h08: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_SUB};  // A <- A - B
            7'h09: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_SUB};
            7'h0A: cw = {3'b010, SEL_A_REG,  SEL_B_LIT,  ALU_SUB};
            7'h0B: cw = {3'b001, SEL_A_B,    SEL_B_LIT,  ALU_SUB};
            7'h0C: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_AND};
            7'h0D: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_AND};
            7'h0E: cw = {3'b010, SEL_A_REG,  SEL_B_LIT,  ALU_AND};
            7'h0F: cw = {3'b001, SEL_A_B,    SEL_B_LIT,  ALU_AND};
            7'h10: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_OR};
            7'h11: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_OR};
            7'h12: cw = {3'b010, SEL_A_REG,  SEL_B_LIT,  ALU_OR};
            7'h13: cw = {3'b001, SEL_A_B,    SEL_B_LIT,  ALU_OR};
            7'h14: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_NOT};  // A <- ~A
            7'h15: cw = {3'b010, SEL_A_B,    SEL_B_REG,  ALU_NOT};  // A <- ~B
            7'h16: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_NOT};
            7'h17: cw = {3'b001, SEL_A_B,    SEL_B_REG,  ALU_NOT};
            7'h18: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_XOR};
            7'h19: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_XOR};
            7'h1A: cw = {3'b010, SEL_A_REG,  SEL_B_LIT,  ALU_XOR};
            7'h1B: cw = {3'b001, SEL_A_B,    SEL_B_LIT,  ALU_XOR};
            7'h1C: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_SHL};
            7'h1D: cw = {3'b010, SEL_A_B,    SEL_B_REG,  ALU_SHL};
            7'h1E: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_SHL};
            7'h1F: cw = {3'b001, SEL_A_B,    SEL_B_REG,  ALU_SHL};
            7'h20: cw = {3'b010, SEL_A_REG,  SEL_B_REG,  ALU_SHR};
            7'h21: cw = {3'b010, SEL_A_B,    SEL_B_REG,  ALU_SHR};
            7'h22: cw = {3'b001, SEL_A_REG,  SEL_B_REG,  ALU_SHR};
            7'h23: cw = {3'b001, SEL_A_B,    SEL_B_REG,  ALU_SHR};
            OPC_JMP, OPC_JZ, OPC_JNZ, OPC_JGT, OPC_JN,
            OPC_JNN, OPC_JLE, OPC_JC, OPC_JV:
                cw = take ? CW_JUMP : '0;  // Not taken so PC increments
            default: cw = '0;
        endcase
    end

    assign o_pc_load = cw[CW_PC_LOAD];
    assign o_load_a  = cw[CW_LOAD_A];
    assign o_load_b  = cw[CW_LOAD_B];
    assign o_sel_a   = cw[CW_SEL_A +: 2];
    assign o_sel_b   = cw[CW_SEL_B +: 2];
    assign o_alu_op  = cw[CW_ALU +: 3];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
/* Eight-operation ALU, fully combinational.
   C comes from a 9-bit subtract for SUB and a 9-bit add for every other op. */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [cpu_pkg::DATA_W-1:0] i_a,
    input  logic [cpu_pkg::DATA_W-1:0] i_b,
    input  logic [2:0]                 i_op,
    output logic [cpu_pkg::DATA_W-1:0] o_result,
    output logic [cpu_pkg::FLAG_W-1:0] o_flags
);
    import cpu_pkg::*;

    logic [DATA_W:0] wide;  // Carry source

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_NOT: o_result = ~i_a;       // B ignored
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_SHL: o_result = i_a << 1;
            ALU_SHR: o_result = i_a >> 1;   // Logical
            default: o_result = '0;
        endcase
    end

    always_comb begin
        if (i_op == ALU_SUB)
            wide = {1'b0, i_a} - {1'b0, i_b};
        else
            wide = {1'b0, i_a} + {1'b0, i_b};
        o_flags         = '0;
        o_flags[FLAG_Z] = (o_result == '0);
        o_flags[FLAG_N] = o_result[DATA_W-1];
        o_flags[FLAG_C] = wide[DATA_W];
        // Same-sign operands with a sign flip in the result
        o_flags[FLAG_V] = (i_a[DATA_W-1] == i_b[DATA_W-1]) &&
                          (o_result[DATA_W-1] != i_a[DATA_W-1]);
    end

endmodule

`default_nettype wire

// ==== hdl/button_debounce.sv ====
/* Debounces one active-low button. o_press pulses one cycle,
   DEBOUNCE_LIMIT+1 cycles after the input settles low. */
`timescale 1ns/1ns
`default_nettype none

module button_debounce #(
    parameter logic [15:0] DEBOUNCE_LIMIT = 16'd10000
) (
    input  logic i_clk,
    input  logic rst,
    input  logic i_btn_n,
    output logic o_press
);

    logic        sample;      // Last seen raw level
    logic [15:0] count;       // Cycles the raw level has held
    logic        level;       // Debounced level
    logic        level_prev;

    always_ff @(posedge i_clk or posedge rst) begin
        if (rst) begin
            sample     <= 1'b1;  // Idle high
            count      <= '0;
            level      <= 1'b1;
            level_prev <= 1'b1;
            o_press    <= 1'b0;
        end else begin
            if (i_btn_n != sample) begin
                sample <= i_btn_n;
                count  <= '0;    // Bounce restarts the wait
            end else if (count < DEBOUNCE_LIMIT) begin
                count <= count + 1'b1;
                if (count == DEBOUNCE_LIMIT - 1'b1)
                    level <= sample;
            end
            level_prev <= level;
            o_press    <= level_prev & ~level;  // Falling edge of level
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
/* Widths, control-word layout and encodings shared by the teaching CPU.
   Memory opcodes 0x24 to 0x52 are not part of this instruction set. */
`default_nettype none

package cpu_pkg;

    localparam int DATA_W   = 8;    // Datapath and register width
    localparam int OPC_W    = 7;    // Opcode field in instr[14:8]
    localparam int INSTR_W  = 15;   // Opcode plus 8-bit literal
    localparam int ADDR_W   = 8;    // Program address
    localparam int FLAG_W   = 4;
    localparam int NIBBLE_W = 4;    // Shown on LEDs and digits

    // Flag word bit positions
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Control word {pc_load, load_a, load_b, sel_a, sel_b, alu_op}
    localparam int CW_W       = 10;
    localparam int CW_PC_LOAD = 9;
    localparam int CW_LOAD_A  = 8;
    localparam int CW_LOAD_B  = 7;
    localparam int CW_SEL_A   = 5;  // Low bit of 2-bit field
    localparam int CW_SEL_B   = 3;  // Low bit of 2-bit field
    localparam int CW_ALU     = 0;  // Low bit of 3-bit field

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_NOT = 3'd4;
    localparam logic [2:0] ALU_XOR = 3'd5;
    localparam logic [2:0] ALU_SHL = 3'd6;
    localparam logic [2:0] ALU_SHR = 3'd7;

    // Operand A sources
    localparam logic [1:0] SEL_A_REG  = 2'd0;
    localparam logic [1:0] SEL_A_ONE  = 2'd1;
    localparam logic [1:0] SEL_A_ZERO = 2'd2;
    localparam logic [1:0] SEL_A_B    = 2'd3;

    // Operand B sources, code 1 reads as zero
    localparam logic [1:0] SEL_B_REG  = 2'd0;
    localparam logic [1:0] SEL_B_LIT  = 2'd2;
    localparam logic [1:0] SEL_B_ZERO = 2'd3;

    localparam logic [6:0] OPC_JMP = 7'h53;  // Unconditional
    localparam logic [6:0] OPC_JZ  = 7'h54;
    localparam logic [6:0] OPC_JNZ = 7'h55;
    localparam logic [6:0] OPC_JGT = 7'h56;  // Z and N both clear
    localparam logic [6:0] OPC_JN  = 7'h57;
    localparam logic [6:0] OPC_JNN = 7'h58;
    localparam logic [6:0] OPC_JLE = 7'h59;  // Z or N set
    localparam logic [6:0] OPC_JC  = 7'h5A;
    localparam logic [6:0] OPC_JV  = 7'h5B;

endpackage

`default_nettype wire
